// ==== hdl/mac_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// widths and opcode constants of the vector multiply unit
// element width enum, uop / stage-1 control / result structs
//////////////////////////////////////////////////////////////////////

package mac_pkg;

    localparam int vlen      = 128;
    localparam int vlenb     = vlen / 8;
    localparam int xlen      = 32;
    localparam int rob_idx_w = 4;
    localparam int funct6_w  = 6;
    localparam int funct3_w  = 3;
    localparam int n_prod    = 4 * vlenb;    // byte products, four 4x4 tiles

    // major opcodes
    localparam logic [funct3_w-1:0] opivv = 3'b000;
    localparam logic [funct3_w-1:0] opmvv = 3'b010;
    localparam logic [funct3_w-1:0] opivx = 3'b100;
    localparam logic [funct3_w-1:0] opmvx = 3'b110;

    // funct6 under opmvv / opmvx
    localparam logic [funct6_w-1:0] f6_vmulhu  = 6'b100100;
    localparam logic [funct6_w-1:0] f6_vmul    = 6'b100101;
    localparam logic [funct6_w-1:0] f6_vmulhsu = 6'b100110;
    localparam logic [funct6_w-1:0] f6_vmulh   = 6'b100111;
    localparam logic [funct6_w-1:0] f6_vmadd   = 6'b101001;
    localparam logic [funct6_w-1:0] f6_vnmsub  = 6'b101011;
    localparam logic [funct6_w-1:0] f6_vmacc   = 6'b101101;
    localparam logic [funct6_w-1:0] f6_vnmsac  = 6'b101111;
    // funct6 under opivv / opivx
    localparam logic [funct6_w-1:0] f6_vsmul   = 6'b100111;

    typedef enum logic [2:0] {
        eew8  = 3'd0,
        eew16 = 3'd1,
        eew32 = 3'd2
    } eew_e;

    typedef struct packed {
        logic [rob_idx_w-1:0] rob_entry;
        logic [funct6_w-1:0]  funct6;
        logic [funct3_w-1:0]  funct3;
        logic [1:0]           vxrm;
        eew_e                 eew;
        logic [vlen-1:0]      vs1_data;
        logic [vlen-1:0]      vs2_data;
        logic [vlen-1:0]      vs3_data;     // old vd
        logic [xlen-1:0]      rs1_data;
    } mac_uop_t;

    typedef struct packed {
        logic                 src2_signed;
        logic                 src1_signed;
        logic                 keep_low;     // low half of product
        logic                 mul_reverse;  // subtract product
        logic                 is_vsmul;
        logic                 is_vmac;
        logic [1:0]           vxrm;
        eew_e                 eew;
        logic [rob_idx_w-1:0] rob_entry;
    } mac_ctrl_t;

    typedef struct packed {
        logic [rob_idx_w-1:0] rob_entry;
        logic [vlen-1:0]      w_data;
        logic [vlenb-1:0]     vsaturate;    // one per byte
    } mac_rslt_t;

endpackage

// ==== hdl/mac_decode.sv ====
//////////////////////////////////////////////////////////////////////
// mac_decode: uop to multiplicands, add source, per-byte sign masks
// and the stage-1 control word
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mac_decode (
    input  logic                       uop_valid,
    input  mac_pkg::mac_uop_t          uop,
    output logic [mac_pkg::vlen-1:0]   src2,
    output logic [mac_pkg::vlen-1:0]   src1,
    output logic [mac_pkg::vlen-1:0]   addsrc,
    output logic [mac_pkg::vlenb-1:0]  src2_sign,
    output logic [mac_pkg::vlenb-1:0]  src1_sign,
    output mac_pkg::mac_ctrl_t         ctrl
);

    import mac_pkg::*;

    logic            is_mop;
    logic            is_vx;
    logic            op_ok;
    logic            s2_signed;
    logic            s1_signed;
    logic            keep_low;
    logic            mul_reverse;
    logic            is_vsmul;
    logic            is_vmac;
    logic            swap;          // vd goes to the multiplier
    logic [vlen-1:0] scalar_rep;

    assign is_mop = (uop.funct3 == opmvv) || (uop.funct3 == opmvx);
    assign is_vx  = (uop.funct3 == opmvx) || (uop.funct3 == opivx);
    assign op_ok  = uop_valid && (is_mop || uop.funct3 == opivv || uop.funct3 == opivx);

    //////////////////////////////////////////////////////////////////////
    // operation class
    always_comb begin
        s2_signed   = 1'b1;
        s1_signed   = 1'b1;
        keep_low    = 1'b1;
        mul_reverse = 1'b0;
        is_vsmul    = 1'b0;
        is_vmac     = 1'b0;
        swap        = 1'b0;
        if (is_mop) begin
            case (uop.funct6)
                f6_vmulh: keep_low = 1'b0;
                f6_vmulhu: begin
                    keep_low  = 1'b0;
                    s2_signed = 1'b0;
                    s1_signed = 1'b0;
                end
                f6_vmulhsu: begin
                    keep_low  = 1'b0;
                    s1_signed = 1'b0;
                end
                f6_vmacc: is_vmac = 1'b1;
                f6_vnmsac: begin
                    is_vmac     = 1'b1;
                    mul_reverse = 1'b1;
                end
                f6_vmadd: begin
                    is_vmac = 1'b1;
                    swap    = 1'b1;
                end
                f6_vnmsub: begin
                    is_vmac     = 1'b1;
                    swap        = 1'b1;
                    mul_reverse = 1'b1;
                end
                default: ;                  // vmul
            endcase
        end else begin
            keep_low = 1'b0;                // integer opcodes are all vsmul
            is_vsmul = 1'b1;
        end
    end

    always_comb begin
        case (uop.eew)
            eew16:   scalar_rep = {8{uop.rs1_data[15:0]}};
            eew32:   scalar_rep = {4{uop.rs1_data}};
            default: scalar_rep = {16{uop.rs1_data[7:0]}};
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // operands and control
    always_comb begin
        src2      = '0;
        src1      = '0;
        addsrc    = '0;
        src2_sign = '0;
        src1_sign = '0;
        ctrl      = '0;
        if (op_ok) begin
            src2   = swap ? uop.vs3_data : uop.vs2_data;
            src1   = is_vx ? scalar_rep : uop.vs1_data;
            addsrc = !is_vmac ? '0 : (swap ? uop.vs2_data : uop.vs3_data);
            case (uop.eew)                  // sign only on the top byte of each element
                eew16: begin
                    src2_sign = {8{s2_signed, 1'b0}};
                    src1_sign = {8{s1_signed, 1'b0}};
                end
                eew32: begin
                    src2_sign = {4{s2_signed, 3'b0}};
                    src1_sign = {4{s1_signed, 3'b0}};
                end
                default: begin
                    src2_sign = {16{s2_signed}};
                    src1_sign = {16{s1_signed}};
                end
            endcase
            ctrl.src2_signed = s2_signed;
            ctrl.src1_signed = s1_signed;
            ctrl.keep_low    = keep_low;
            ctrl.mul_reverse = mul_reverse;
            ctrl.is_vsmul    = is_vsmul;
            ctrl.is_vmac     = is_vmac;
            ctrl.vxrm        = uop.vxrm;
            ctrl.eew         = uop.eew;
            ctrl.rob_entry   = uop.rob_entry;
        end
    end

    // reservation station only issues legal element widths
    always_comb begin
        if (uop_valid) begin
            assert (uop.eew inside {eew8, eew16, eew32})
                else $error("mac_decode: illegal eew %0d", uop.eew);
        end
    end

endmodule

// ==== hdl/mac_mul_array.sv ====
//////////////////////////////////////////////////////////////////////
// 64 signed/unsigned 8x8 multipliers in four 4x4 tiles
// stage-0 pipeline registers
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mac_mul_array (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 vld_en,
    input  logic                                 data_en,
    input  logic                                 uop_valid,
    input  logic [mac_pkg::vlen-1:0]             src2,
    input  logic [mac_pkg::vlen-1:0]             src1,
    input  logic [mac_pkg::vlenb-1:0]            src2_sign,
    input  logic [mac_pkg::vlenb-1:0]            src1_sign,
    input  logic [mac_pkg::vlen-1:0]             addsrc,
    input  mac_pkg::mac_ctrl_t                   ctrl_in,
    output logic [mac_pkg::n_prod-1:0][15:0]     prod,
    output logic [mac_pkg::vlen-1:0]             addsrc_q,
    output mac_pkg::mac_ctrl_t                   ctrl_q,
    output logic                                 valid_q
);

    import mac_pkg::*;

    logic [n_prod-1:0][15:0] prod_d;

    // tile z pairs bytes 4z..4z+3 of both sources
    for (genvar z = 0; z < vlenb / 4; z++) begin : g_tile
        for (genvar x = 0; x < 4; x++) begin : g_x
            logic signed [15:0] a;
            assign a = {{8{src2_sign[z*4+x] & src2[(z*4+x)*8+7]}}, src2[(z*4+x)*8 +: 8]};
            for (genvar y = 0; y < 4; y++) begin : g_y
                logic signed [15:0] b;
                assign b = {{8{src1_sign[z*4+y] & src1[(z*4+y)*8+7]}}, src1[(z*4+y)*8 +: 8]};
                assign prod_d[z*16+y*4+x] = a * b;  // exact in 16 bits
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage-0 registers
    always_ff @(posedge clk) begin
        if (data_en) begin
            prod     <= prod_d;
            addsrc_q <= addsrc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            if (data_en) begin
                ctrl_q <= ctrl_in;
            end
            if (vld_en) begin
                valid_q <= uop_valid;
            end
        end
    end

    // an accepted uop must load its operands too
    a_accept_loads_data: assert property (@(posedge clk) disable iff (rst)
        vld_en && uop_valid |-> data_en)
        else $error("mac_mul_array: uop accepted without data enable");

endmodule

// ==== hdl/mac_elem_sum.sv ====
//////////////////////////////////////////////////////////////////////
// mac_elem_sum: double-width element products for sew 8/16/32
// built from the registered byte products
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mac_elem_sum (
    input  logic [mac_pkg::n_prod-1:0][15:0]  prod,
    input  logic                              src2_signed,
    input  logic                              src1_signed,
    output logic [2*mac_pkg::vlen-1:0]        full8,
    output logic [2*mac_pkg::vlen-1:0]        full16,
    output logic [2*mac_pkg::vlen-1:0]        full32
);

    import mac_pkg::*;

    // sum of the nb x nb partial products of one element, starting at
    // byte b0 of tile z; a term is sign extended only if it carries a
    // top byte of a signed source
    function automatic logic [63:0] elem_mul(
        input logic [n_prod-1:0][15:0] p,
        input int                      z,
        input int                      b0,
        input int                      nb,
        input logic                    s2,
        input logic                    s1
    );
        logic [63:0] acc;
        logic [15:0] pp;
        logic        ext;
        acc = '0;
        for (int x = 0; x < nb; x++) begin
            for (int y = 0; y < nb; y++) begin
                pp  = p[z*16 + (b0+y)*4 + b0 + x];
                ext = pp[15] & ((x == nb-1 && s2) || (y == nb-1 && s1));
                acc = acc + ({{48{ext}}, pp} << (8*(x+y)));
            end
        end
        return acc;
    endfunction

    // sew 8, diagonal products only
    for (genvar e = 0; e < vlenb; e++) begin : g_e8
        assign full8[16*e +: 16] = 16'(elem_mul(prod, e/4, e%4, 1, src2_signed, src1_signed));
    end

    // sew 16, two elements per tile
    for (genvar e = 0; e < vlenb / 2; e++) begin : g_e16
        assign full16[32*e +: 32] = 32'(elem_mul(prod, e/2, 2*(e%2), 2,
                                                 src2_signed, src1_signed));
    end

    // sew 32, whole tile
    for (genvar e = 0; e < vlenb / 4; e++) begin : g_e32
        assign full32[64*e +: 64] = elem_mul(prod, e, 0, 4, src2_signed, src1_signed);
    end

endmodule

// ==== hdl/mac_writeback.sv ====
//////////////////////////////////////////////////////////////////////
// mac_writeback: high/low select, accumulate, vsmul round and
// saturate per element width, final eew mux
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mac_writeback (
    input  logic [2*mac_pkg::vlen-1:0]  full8,
    input  logic [2*mac_pkg::vlen-1:0]  full16,
    input  logic [2*mac_pkg::vlen-1:0]  full32,
    input  logic [mac_pkg::vlen-1:0]    addsrc_q,
    input  mac_pkg::mac_ctrl_t          ctrl_q,
    output mac_pkg::mac_rslt_t          rslt
);

    import mac_pkg::*;

    for (genvar w = 0; w < 3; w++) begin : g_sew
        localparam int sew = 8 << w;
        localparam int ne  = vlen / sew;

        logic [2*vlen-1:0] full;
        logic [vlen-1:0]   res;
        logic [vlenb-1:0]  sat;

        assign full = (w == 0) ? full8 : ((w == 1) ? full16 : full32);

        for (genvar e = 0; e < ne; e++) begin : g_elem
            logic [2*sew-1:0] p;
            logic [sew-1:0]   half;
            logic [sew-1:0]   acc;
            logic [sew-1:0]   rnd;
            logic             incr;
            logic             ovf;
            logic [sew/8-1:0] sbyte;

            assign p    = full[2*sew*e +: 2*sew];
            assign half = ctrl_q.keep_low ? p[sew-1:0] : p[2*sew-1:sew];
            assign acc  = ctrl_q.mul_reverse ? addsrc_q[sew*e +: sew] - half
                                             : addsrc_q[sew*e +: sew] + half;
            assign ovf  = (p[2*sew-1 -: 2] == 2'b01);   // only -2^(sew-1) squared

            // vsmul shifts right by sew-1
            always_comb begin
                case (ctrl_q.vxrm)
                    2'd0:    incr = p[sew-2];                              // rnu
                    2'd1:    incr = p[sew-2] & ((|p[sew-3:0]) | p[sew-1]); // rne
                    2'd2:    incr = 1'b0;                                  // rdn
                    default: incr = ~p[sew-1] & (|p[sew-2:0]);             // rod
                endcase
            end

            assign rnd = ovf ? {1'b0, {(sew-1){1'b1}}}
                             : p[sew-1 +: sew] + {{(sew-1){1'b0}}, incr};

            assign res[sew*e +: sew] = ctrl_q.is_vmac  ? acc :
                                       ctrl_q.is_vsmul ? rnd : half;

            always_comb begin
                sbyte          = '0;
                sbyte[sew/8-1] = ctrl_q.is_vsmul & ovf;    // flag at top byte
            end
            assign sat[sew/8*e +: sew/8] = sbyte;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // result by element width
    always_comb begin
        rslt.rob_entry = ctrl_q.rob_entry;
        case (ctrl_q.eew)
            eew16: begin
                rslt.w_data    = g_sew[1].res;
                rslt.vsaturate = g_sew[1].sat;
            end
            eew32: begin
                rslt.w_data    = g_sew[2].res;
                rslt.vsaturate = g_sew[2].sat;
            end
            default: begin
                rslt.w_data    = g_sew[0].res;
                rslt.vsaturate = g_sew[0].sat;
            end
        endcase
    end

endmodule

// ==== hdl/mac_unit.sv ====
//////////////////////////////////////////////////////////////////////
// mac_unit: vector multiply / multiply-accumulate, one stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mac_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                uop_valid,
    input  mac_pkg::mac_uop_t   uop,
    input  logic                stg0_vld_en,
    input  logic                stg0_data_en,
    output logic                rslt_valid,
    output mac_pkg::mac_rslt_t  rslt
);

    import mac_pkg::*;

    logic [vlen-1:0]         src2;
    logic [vlen-1:0]         src1;
    logic [vlen-1:0]         addsrc;
    logic [vlenb-1:0]        src2_sign;
    logic [vlenb-1:0]        src1_sign;
    mac_ctrl_t               ctrl;
    logic [n_prod-1:0][15:0] prod;
    logic [vlen-1:0]         addsrc_q;
    mac_ctrl_t               ctrl_q;
    logic [2*vlen-1:0]       full8;
    logic [2*vlen-1:0]       full16;
    logic [2*vlen-1:0]       full32;

    mac_decode mac_decode_inst (
        .uop_valid (uop_valid),
        .uop       (uop),
        .src2      (src2),
        .src1      (src1),
        .addsrc    (addsrc),
        .src2_sign (src2_sign),
        .src1_sign (src1_sign),
        .ctrl      (ctrl)
    );

    mac_mul_array mac_mul_array_inst (
        .clk       (clk),
        .rst       (rst),
        .vld_en    (stg0_vld_en),
        .data_en   (stg0_data_en),
        .uop_valid (uop_valid),
        .src2      (src2),
        .src1      (src1),
        .src2_sign (src2_sign),
        .src1_sign (src1_sign),
        .addsrc    (addsrc),
        .ctrl_in   (ctrl),
        .prod      (prod),
        .addsrc_q  (addsrc_q),
        .ctrl_q    (ctrl_q),
        .valid_q   (rslt_valid)
    );

    mac_elem_sum mac_elem_sum_inst (
        .prod        (prod),
        .src2_signed (ctrl_q.src2_signed),
        .src1_signed (ctrl_q.src1_signed),
        .full8       (full8),
        .full16      (full16),
        .full32      (full32)
    );

    mac_writeback mac_writeback_inst (
        .full8    (full8),
        .full16   (full16),
        .full32   (full32),
        .addsrc_q (addsrc_q),
        .ctrl_q   (ctrl_q),
        .rslt     (rslt)
    );

endmodule

// ==== dv/mac_unit_tb.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for mac_unit
// clock and reset, random uops with random stage enables
// element-wise reference model and checking assertions
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mac_unit_tb;

    import mac_pkg::*;

    localparam int n_uops     = 600;
    localparam int timeout_ns = (10 + 4 * n_uops + 200) * 4;   // under 4 cycles per uop

    logic      clk;
    logic      rst;
    logic      uop_valid;
    mac_uop_t  uop;
    logic      stg0_vld_en;
    logic      stg0_data_en;
    logic      rslt_valid;
    mac_rslt_t rslt;

    logic      exp_valid;
    mac_rslt_t exp_rslt;
    int        n_sat = 0;           // accepted uops with a saturated element

    mac_unit mac_unit_inst (
        .clk          (clk),
        .rst          (rst),
        .uop_valid    (uop_valid),
        .uop          (uop),
        .stg0_vld_en  (stg0_vld_en),
        .stg0_data_en (stg0_data_en),
        .rslt_valid   (rslt_valid),
        .rslt         (rslt)
    );

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input logic [127:0] exp_v,
                                   input logic [127:0] got_v);
        $display("MISMATCH time=%0t %s expected=%h got=%h", $time, sig, exp_v, got_v);
        abort_run();
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model
    function automatic logic [31:0] elem(input logic [127:0] vec, input int sew, input int e);
        logic [127:0] t;
        t = (vec >> (sew * e)) & ((128'd1 << sew) - 128'd1);
        return t[31:0];
    endfunction

    function automatic logic [63:0] extend(input logic [31:0] v, input int sew, input bit sgn);
        logic [63:0] m;
        logic [63:0] x;
        m = (64'd1 << sew) - 64'd1;
        x = {32'd0, v} & m;
        if (sgn && v[sew-1]) begin
            x = x | ~m;
        end
        return x;
    endfunction

    function automatic mac_rslt_t ref_model(input mac_uop_t u);
        mac_rslt_t   r;
        int          sew;
        int          d;
        logic [63:0] m;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [63:0] a64;
        logic [63:0] b64;
        logic [63:0] c64;
        logic [63:0] p;
        logic [63:0] v;
        longint      q;
        longint      lim;
        bit          vx;
        bit          inc;
        r           = '0;
        r.rob_entry = u.rob_entry;
        sew = 8 << int'(u.eew);
        d   = sew - 1;
        m   = (64'd1 << sew) - 64'd1;
        lim = (longint'(1) << d) - 1;
        vx  = (u.funct3 == opmvx) || (u.funct3 == opivx);
        for (int e = 0; e < 128 / sew; e++) begin
            a   = elem(u.vs2_data, sew, e);
            b   = vx ? elem({96'd0, u.rs1_data}, sew, 0) : elem(u.vs1_data, sew, e);
            c   = elem(u.vs3_data, sew, e);     // old vd
            a64 = {32'd0, a};
            b64 = {32'd0, b};
            c64 = {32'd0, c};
            if ((u.funct3 == opmvv) || (u.funct3 == opmvx)) begin
                case (u.funct6)
                    f6_vmulh:   v = (extend(a, sew, 1'b1) * extend(b, sew, 1'b1)) >> sew;
                    f6_vmulhu:  v = (extend(a, sew, 1'b0) * extend(b, sew, 1'b0)) >> sew;
                    f6_vmulhsu: v = (extend(a, sew, 1'b1) * extend(b, sew, 1'b0)) >> sew;
                    f6_vmacc:   v = c64 + b64 * a64;
                    f6_vnmsac:  v = c64 - b64 * a64;
                    f6_vmadd:   v = b64 * c64 + a64;
                    f6_vnmsub:  v = a64 - b64 * c64;
                    default:    v = a64 * b64;  // vmul and unknown codes
                endcase
            end else begin
                p = extend(a, sew, 1'b1) * extend(b, sew, 1'b1);
                case (u.vxrm)
                    2'd0:    inc = p[d-1];
                    2'd1:    inc = p[d-1] & (((p & ((64'd1 << (d-1)) - 64'd1)) != 64'd0) | p[d]);
                    2'd2:    inc = 1'b0;
                    default: inc = ~p[d] & ((p & ((64'd1 << d) - 64'd1)) != 64'd0);
                endcase
                q = ($signed(p) >>> d) + longint'(inc);
                if (q > lim) begin
                    q = lim;
                    r.vsaturate[e*(sew/8) + sew/8 - 1] = 1'b1;
                end
                v = 64'(q);
            end
            r.w_data = r.w_data | (128'(v & m) << (sew * e));
        end
        return r;
    endfunction

    // one expected entry loaded when the DUT accepts a uop
    always @(posedge clk) begin
        mac_rslt_t r;
        if (rst) begin
            exp_valid <= 1'b0;
        end else if (stg0_vld_en) begin
            exp_valid <= uop_valid;
            if (uop_valid) begin
                r = ref_model(uop);
                exp_rslt <= r;
                if (r.vsaturate != '0) begin
                    n_sat <= n_sat + 1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    a_rst_low: assert property (@(posedge clk) rst && $past(rst) |-> !rslt_valid)
        else begin
            $display("ERROR time=%0t: rslt_valid high during reset", $time);
            abort_run();
        end

    a_valid: assert property (@(posedge clk) !rst |-> rslt_valid == exp_valid)
        else report_mismatch("rslt_valid", 128'($sampled(exp_valid)),
                             128'($sampled(rslt_valid)));

    a_hold: assert property (@(posedge clk)
        !rst && !$past(rst) && !$past(stg0_vld_en) |-> $stable(rslt_valid) && $stable(rslt))
        else begin
            $display("ERROR time=%0t: result changed while stg0_vld_en was low", $time);
            abort_run();
        end

    a_data: assert property (@(posedge clk) !rst && rslt_valid |-> rslt.w_data == exp_rslt.w_data)
        else report_mismatch("rslt.w_data", $sampled(exp_rslt.w_data), $sampled(rslt.w_data));

    a_sat: assert property (@(posedge clk)
        !rst && rslt_valid |-> rslt.vsaturate == exp_rslt.vsaturate)
        else report_mismatch("rslt.vsaturate", 128'($sampled(exp_rslt.vsaturate)),
                             128'($sampled(rslt.vsaturate)));

    a_rob: assert property (@(posedge clk)
        !rst && rslt_valid |-> rslt.rob_entry == exp_rslt.rob_entry)
        else report_mismatch("rslt.rob_entry", 128'($sampled(exp_rslt.rob_entry)),
                             128'($sampled(rslt.rob_entry)));

    //////////////////////////////////////////////////////////////////////
    // stimulus
    function automatic logic [127:0] rand_vec();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    function automatic logic [127:0] min_vec(input eew_e w);   // -2^(sew-1) in every element
        case (w)
            eew16:   return {8{16'h8000}};
            eew32:   return {4{32'h8000_0000}};
            default: return {16{8'h80}};
        endcase
    endfunction

    function automatic logic [2:0] pick_funct3(input int k);
        case (k)
            0:       return opmvv;
            1:       return opmvx;
            2:       return opivv;
            default: return opivx;
        endcase
    endfunction

    function automatic logic [5:0] pick_mop_f6(input int k);
        case (k)
            0:       return f6_vmul;
            1:       return f6_vmulh;
            2:       return f6_vmulhu;
            3:       return f6_vmulhsu;
            4:       return f6_vmacc;
            5:       return f6_vnmsac;
            6:       return f6_vmadd;
            7:       return f6_vnmsub;
            8:       return 6'b000011;      // not a multiply code
            default: return 6'b110000;
        endcase
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(timeout_ns);
        $display("ERROR time=%0t: watchdog expired before %0d uops completed", $time, n_uops);
        abort_run();
    end

    initial begin
        mac_uop_t u;
        int       accepted;
        bit       en;
        bit       vld;
        void'($urandom(32'h7ef8_7f8a));
        rst          = 1'b1;
        uop_valid    = 1'b1;                // valid held high through reset
        uop          = '0;
        stg0_vld_en  = 1'b1;
        stg0_data_en = 1'b1;
        accepted     = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        while (accepted < n_uops) begin
            @(posedge clk);
            en  = ($urandom_range(0, 5) != 0);  // occasional stall
            vld = ($urandom_range(0, 4) != 0);
            u.rob_entry = 4'($urandom);
            u.funct3    = pick_funct3(int'($urandom_range(0, 3)));
            u.funct6    = ((u.funct3 == opmvv) || (u.funct3 == opmvx))
                          ? pick_mop_f6(int'($urandom_range(0, 9))) : f6_vsmul;
            u.vxrm      = 2'($urandom);
            u.eew       = eew_e'($urandom_range(0, 2));
            u.vs1_data  = rand_vec();
            u.vs2_data  = rand_vec();
            u.vs3_data  = rand_vec();
            u.rs1_data  = $urandom;
            if ($urandom_range(0, 7) == 0) begin    // saturation corner
                u.vs1_data = min_vec(u.eew);
                u.vs2_data = min_vec(u.eew);
                u.vs3_data = min_vec(u.eew);
                u.rs1_data = u.vs1_data[31:0];
            end
            uop          <= u;
            uop_valid    <= vld;
            stg0_vld_en  <= en;
            stg0_data_en <= en;
            if (en && vld) begin
                accepted++;
            end
        end
        @(posedge clk);
        uop_valid    <= 1'b0;
        stg0_vld_en  <= 1'b1;
        stg0_data_en <= 1'b1;
        repeat (3) @(posedge clk);
        if (n_sat == 0) begin
            $display("ERROR: no saturating vsmul was exercised");
            abort_run();
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
hdl/mac_pkg.sv
hdl/mac_decode.sv
hdl/mac_mul_array.sv
hdl/mac_elem_sum.sv
hdl/mac_writeback.sv
hdl/mac_unit.sv
dv/mac_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the mac_unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module mac_unit_tb \
    -f sources.f \
    -Mdir obj_dir

./obj_dir/Vmac_unit_tb
